/* ooo_backend_pkg.sv */
`default_nettype none

package ooo_backend_pkg;

    // datapath and tag widths
    localparam int XLEN   = 32;
    localparam int PREG_W = 6;   // 64 physical registers

    // integer ops handled by the ALU lanes
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,   // signed compare
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7    // shifts use b[4:0]
    } alu_op_e;

    // one dispatched instruction, as it sits in an issue queue entry
    typedef struct packed {
        alu_op_e           op;
        logic [PREG_W-1:0] src0_preg;
        logic              src0_rdy;    // src0_data holds the operand
        logic [XLEN-1:0]   src0_data;
        logic [PREG_W-1:0] src1_preg;
        logic              src1_rdy;
        logic [XLEN-1:0]   src1_data;
        logic [PREG_W-1:0] dst_preg;
    } issue_pkt_t;

    // result on its way to the CDB, and the broadcast itself
    typedef struct packed {
        logic [PREG_W-1:0] rob_id;      // destination tag
        logic [XLEN-1:0]   w_data;
    } cdb_info_t;

endpackage

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu (
    input  wire ooo_backend_pkg::alu_op_e        op_i,
    input  wire [ooo_backend_pkg::XLEN-1:0]      a_i,
    input  wire [ooo_backend_pkg::XLEN-1:0]      b_i,
    output logic [ooo_backend_pkg::XLEN-1:0]     result_o
);

    always_comb begin
        case (op_i)
            ooo_backend_pkg::ALU_ADD: result_o = a_i + b_i;
            ooo_backend_pkg::ALU_SUB: result_o = a_i - b_i;
            ooo_backend_pkg::ALU_AND: result_o = a_i & b_i;
            ooo_backend_pkg::ALU_OR:  result_o = a_i | b_i;
            ooo_backend_pkg::ALU_XOR: result_o = a_i ^ b_i;
            ooo_backend_pkg::ALU_SLT: begin
                result_o    = '0;
                result_o[0] = $signed(a_i) < $signed(b_i);
            end
            ooo_backend_pkg::ALU_SLL: result_o = a_i << b_i[4:0];
            ooo_backend_pkg::ALU_SRL: result_o = a_i >> b_i[4:0];   // logical
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* alu_iq.sv */
`default_nettype none

module alu_iq #(
    parameter int IQ_DEPTH = 4
) (
    input  wire                                 clk,
    input  wire                                 arst_n_i,
    input  wire                                 flush_i,

    input  wire                                 dispatch_valid_i,
    input  wire ooo_backend_pkg::issue_pkt_t    dispatch_pkt_i,
    output logic                                entry_ready_o,

    input  wire                                 cdb_valid_i,
    input  wire ooo_backend_pkg::cdb_info_t     cdb_i,

    input  wire                                 fifo_full_i,
    output logic                                result_push_o,
    output ooo_backend_pkg::cdb_info_t          result_o
);

    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    logic [IQ_DEPTH-1:0]               entry_valid;
    ooo_backend_pkg::issue_pkt_t       entry_pkt [IQ_DEPTH];
    logic [IQ_DEPTH-1:0][IQ_DEPTH-1:0] older;   // older[i][j] set when i came before j

    logic [IQ_DEPTH-1:0]              free_vec;
    logic [IQ_DEPTH-1:0]              ready_vec;
    logic [IQ_DEPTH-1:0]              grant_vec;
    logic [IDX_W-1:0]                 alloc_idx;
    logic [IDX_W-1:0]                 issue_idx;
    logic                             do_alloc;
    logic                             do_issue;
    ooo_backend_pkg::issue_pkt_t      issue_pkt;
    logic [ooo_backend_pkg::XLEN-1:0] alu_result;

    // snoop one CDB broadcast into any source still waiting on it
    function automatic ooo_backend_pkg::issue_pkt_t wakeup(
        input ooo_backend_pkg::issue_pkt_t pkt,
        input logic                        bcast_valid,
        input ooo_backend_pkg::cdb_info_t  info
    );
        ooo_backend_pkg::issue_pkt_t woken;
        woken = pkt;
        if (bcast_valid && !pkt.src0_rdy && pkt.src0_preg == info.rob_id) begin
            woken.src0_rdy  = 1'b1;
            woken.src0_data = info.w_data;
        end
        if (bcast_valid && !pkt.src1_rdy && pkt.src1_preg == info.rob_id) begin
            woken.src1_rdy  = 1'b1;
            woken.src1_data = info.w_data;
        end
        return woken;
    endfunction

    assign free_vec      = ~entry_valid;
    assign entry_ready_o = (|free_vec) & ~flush_i;
    assign do_alloc      = dispatch_valid_i & entry_ready_o;

    // lowest free slot takes the new instruction
    always_comb begin
        alloc_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                alloc_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            ready_vec[i] = entry_valid[i] & entry_pkt[i].src0_rdy & entry_pkt[i].src1_rdy;
        end
    end

    // oldest ready entry wins, no other ready entry may be older
    always_comb begin
        grant_vec = '0;
        issue_idx = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            grant_vec[i] = ready_vec[i];
            for (int j = 0; j < IQ_DEPTH; j++) begin
                if (j != i && ready_vec[j] && older[j][i]) begin
                    grant_vec[i] = 1'b0;
                end
            end
            if (grant_vec[i]) begin
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign do_issue  = (|grant_vec) & ~fifo_full_i;   // full fifo stalls issue
    assign issue_pkt = entry_pkt[issue_idx];

    alu alu_i (
        .op_i    (issue_pkt.op),
        .a_i     (issue_pkt.src0_data),
        .b_i     (issue_pkt.src1_data),
        .result_o(alu_result)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            entry_valid   <= '0;
            older         <= '0;
            result_push_o <= 1'b0;
        end else if (flush_i) begin
            entry_valid   <= '0;
            result_push_o <= 1'b0;
        end else begin
            if (do_issue) begin
                entry_valid[issue_idx] <= 1'b0;
            end
            if (do_alloc) begin
                entry_valid[alloc_idx] <= 1'b1;
                for (int j = 0; j < IQ_DEPTH; j++) begin
                    older[alloc_idx][j] <= 1'b0;   // newest is older than nobody
                    older[j][alloc_idx] <= (j != alloc_idx);
                end
            end
            // result stage holds while the fifo is full
            if (!fifo_full_i) begin
                result_push_o <= do_issue;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            entry_pkt[i] <= wakeup(entry_pkt[i], cdb_valid_i, cdb_i);
        end
        if (do_alloc) begin
            entry_pkt[alloc_idx] <= wakeup(dispatch_pkt_i, cdb_valid_i, cdb_i);
        end
        if (do_issue) begin
            result_o.rob_id <= issue_pkt.dst_preg;
            result_o.w_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

/* result_fifo.sv */
`default_nettype none

module result_fifo #(
    parameter int FIFO_DEPTH = 2
) (
    input  wire                             clk,
    input  wire                             arst_n_i,
    input  wire                             flush_i,

    input  wire                             push_i,
    input  wire ooo_backend_pkg::cdb_info_t push_data_i,
    output logic                            full_o,

    input  wire                             pop_i,
    output logic                            not_empty_o,
    output ooo_backend_pkg::cdb_info_t      head_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    ooo_backend_pkg::cdb_info_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    logic                       do_push;
    logic                       do_pop;

    // wrap at depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o      = (count == CNT_W'(FIFO_DEPTH));
    assign not_empty_o = (count != '0);
    assign head_o      = mem[rd_ptr];
    assign do_push     = push_i & ~full_o;
    assign do_pop      = pop_i & not_empty_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

/* cdb_arbiter.sv */
`default_nettype none

module cdb_arbiter (
    input  wire                             clk,
    input  wire                             arst_n_i,
    input  wire                             flush_i,

    input  wire [1:0]                       not_empty_i,
    input  wire ooo_backend_pkg::cdb_info_t head0_i,
    input  wire ooo_backend_pkg::cdb_info_t head1_i,
    output logic [1:0]                      pop_o,

    output logic                            cdb_valid_o,
    output ooo_backend_pkg::cdb_info_t      cdb_o
);

    logic last_grant;   // lane that won the previous grant

    // one pop per cycle, alternate when both lanes have data
    always_comb begin
        pop_o = 2'b00;
        if (!flush_i) begin
            if (not_empty_i == 2'b11) begin
                pop_o[0] = last_grant;
                pop_o[1] = ~last_grant;
            end else begin
                pop_o = not_empty_i;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_grant  <= 1'b1;   // so lane 0 goes first
            cdb_valid_o <= 1'b0;
        end else if (flush_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= |pop_o;
            if (|pop_o) begin
                last_grant <= pop_o[1];
            end
        end
    end

    // registered broadcast, also the wakeup seen by both queues
    always_ff @(posedge clk) begin
        if (pop_o[1]) begin
            cdb_o <= head1_i;
        end else if (pop_o[0]) begin
            cdb_o <= head0_i;
        end
    end

endmodule

`default_nettype wire

/* ooo_backend.sv */
`default_nettype none

module ooo_backend #(
    parameter int IQ_DEPTH   = 4,
    parameter int FIFO_DEPTH = 2
) (
    input  wire                              clk,
    input  wire                              arst_n_i,
    input  wire                              flush_i,

    input  wire                              dispatch0_valid_i,
    input  wire ooo_backend_pkg::issue_pkt_t dispatch0_pkt_i,
    output wire                              dispatch0_ready_o,

    input  wire                              dispatch1_valid_i,
    input  wire ooo_backend_pkg::issue_pkt_t dispatch1_pkt_i,
    output wire                              dispatch1_ready_o,

    output wire                              cdb_valid_o,
    output wire ooo_backend_pkg::cdb_info_t  cdb_o
);

    // queue to fifo, per lane
    wire                             iq0_push;
    wire                             iq1_push;
    wire ooo_backend_pkg::cdb_info_t iq0_result;
    wire ooo_backend_pkg::cdb_info_t iq1_result;
    wire                             fifo0_full;
    wire                             fifo1_full;

    // fifo to arbiter
    wire [1:0]                       fifo_not_empty;
    wire [1:0]                       fifo_pop;
    wire ooo_backend_pkg::cdb_info_t fifo0_head;
    wire ooo_backend_pkg::cdb_info_t fifo1_head;

    alu_iq #(
        .IQ_DEPTH(IQ_DEPTH)
    ) alu_iq0_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .dispatch_valid_i(dispatch0_valid_i),
        .dispatch_pkt_i  (dispatch0_pkt_i),
        .entry_ready_o   (dispatch0_ready_o),
        .cdb_valid_i     (cdb_valid_o),     // broadcast doubles as wakeup
        .cdb_i           (cdb_o),
        .fifo_full_i     (fifo0_full),
        .result_push_o   (iq0_push),
        .result_o        (iq0_result)
    );

    alu_iq #(
        .IQ_DEPTH(IQ_DEPTH)
    ) alu_iq1_i (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .dispatch_valid_i(dispatch1_valid_i),
        .dispatch_pkt_i  (dispatch1_pkt_i),
        .entry_ready_o   (dispatch1_ready_o),
        .cdb_valid_i     (cdb_valid_o),
        .cdb_i           (cdb_o),
        .fifo_full_i     (fifo1_full),
        .result_push_o   (iq1_push),
        .result_o        (iq1_result)
    );

    result_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) result_fifo0_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .push_i     (iq0_push),
        .push_data_i(iq0_result),
        .full_o     (fifo0_full),
        .pop_i      (fifo_pop[0]),
        .not_empty_o(fifo_not_empty[0]),
        .head_o     (fifo0_head)
    );

    result_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) result_fifo1_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .push_i     (iq1_push),
        .push_data_i(iq1_result),
        .full_o     (fifo1_full),
        .pop_i      (fifo_pop[1]),
        .not_empty_o(fifo_not_empty[1]),
        .head_o     (fifo1_head)
    );

    cdb_arbiter cdb_arbiter_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .not_empty_i(fifo_not_empty),
        .head0_i    (fifo0_head),
        .head1_i    (fifo1_head),
        .pop_o      (fifo_pop),
        .cdb_valid_o(cdb_valid_o),
        .cdb_o      (cdb_o)
    );

endmodule

`default_nettype wire

/* cdb_checker.sv */
`default_nettype none

module cdb_checker (
    input wire                             clk_i,
    input wire                             cdb_valid_i,
    input wire ooo_backend_pkg::cdb_info_t cdb_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TAGS = 2 ** ooo_backend_pkg::PREG_W;

    logic                             pending [NUM_TAGS];
    logic [ooo_backend_pkg::XLEN-1:0] expected [NUM_TAGS];
    int                               outstanding;
    int                               error_count;

    initial begin
        for (int i = 0; i < NUM_TAGS; i++) begin
            pending[i]  = 1'b0;
            expected[i] = '0;
        end
        outstanding = 0;
        error_count = 0;
    end

    task automatic add_expected(input logic [ooo_backend_pkg::PREG_W-1:0] tag,
                                input logic [ooo_backend_pkg::XLEN-1:0] data);
        if (pending[tag]) begin
            $display("tag %h is expected twice within one test", tag);
            error_count++;
        end else begin
            pending[tag] = 1'b1;
            outstanding++;
        end
        expected[tag] = data;
    endtask

    // drop whatever never arrived so the next test starts clean
    task automatic report_missing();
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (pending[i]) begin
                $display("tag %h was never broadcast on the CDB", i[5:0]);
                error_count++;
                pending[i] = 1'b0;
            end
        end
        outstanding = 0;
    endtask

    // DUT outputs only move on the rising edge
    always @(negedge clk_i) begin
        if ($isunknown(cdb_valid_i)) begin
            $display("cdb_valid_o is unknown at %0t", $time);
            error_count++;
        end else if (cdb_valid_i) begin
            if (!pending[cdb_i.rob_id]) begin
                $display("broadcast of tag %h that is unknown or repeated", cdb_i.rob_id);
                error_count++;
            end else begin
                if (cdb_i.w_data !== expected[cdb_i.rob_id]) begin
                    $display("Fail: cdb_o.w_data tag %h expected %h got %h",
                             cdb_i.rob_id, expected[cdb_i.rob_id], cdb_i.w_data);
                    error_count++;
                end
                pending[cdb_i.rob_id] = 1'b0;
                outstanding--;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_ooo_backend.sv */
`default_nettype none

module tb_ooo_backend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IQ_DEPTH   = 4;
    localparam int FIFO_DEPTH = 2;
    localparam int MAX_RECS   = 64;
    localparam int REC_WORDS  = 12;   // words per record in the stimulus file
    localparam int TIMEOUT    = 300;  // cycles per wait

    logic                        clk;
    logic                        arst_n_i;
    logic                        flush_i;
    logic                        dispatch0_valid;
    logic                        dispatch1_valid;
    ooo_backend_pkg::issue_pkt_t dispatch0_pkt;
    ooo_backend_pkg::issue_pkt_t dispatch1_pkt;
    wire                         dispatch0_ready;
    wire                         dispatch1_ready;
    wire                         cdb_valid;
    ooo_backend_pkg::cdb_info_t  cdb;

    logic [31:0]                 stim_words [MAX_RECS*REC_WORDS];
    int                          rec_test [MAX_RECS];
    int                          rec_lane [MAX_RECS];
    ooo_backend_pkg::issue_pkt_t rec_pkt [MAX_RECS];
    logic [31:0]                 rec_exp [MAX_RECS];
    int                          rec_mark [MAX_RECS];  // 1 flushed, 2 lane must stall
    int                          num_recs;

    logic [31:0] lfsr_state;
    logic        timed_out;
    logic [1:0]  ready_dropped;
    int          tb_errors;
    int          tests_run;
    int          tests_failed;

    ooo_backend #(
        .IQ_DEPTH  (IQ_DEPTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) ooo_backend_i (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .dispatch0_valid_i(dispatch0_valid),
        .dispatch0_pkt_i  (dispatch0_pkt),
        .dispatch0_ready_o(dispatch0_ready),
        .dispatch1_valid_i(dispatch1_valid),
        .dispatch1_pkt_i  (dispatch1_pkt),
        .dispatch1_ready_o(dispatch1_ready),
        .cdb_valid_o      (cdb_valid),
        .cdb_o            (cdb)
    );

    cdb_checker cdb_checker_i (
        .clk_i      (clk),
        .cdb_valid_i(cdb_valid),
        .cdb_i      (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    task automatic load_stimulus();
        int base;
        $readmemh("ooo_backend_stimulus.txt", stim_words);
        num_recs = 0;
        for (int r = 0; r < MAX_RECS; r++) begin
            base = r * REC_WORDS;
            if ($isunknown(stim_words[base]) || stim_words[base] == 32'hff) begin
                break;
            end
            rec_test[r]          = int'(stim_words[base]);
            rec_lane[r]          = int'(stim_words[base+1]);
            rec_pkt[r].op        = ooo_backend_pkg::alu_op_e'(stim_words[base+2][2:0]);
            rec_pkt[r].src0_preg = stim_words[base+3][5:0];
            rec_pkt[r].src0_rdy  = stim_words[base+4][0];
            rec_pkt[r].src0_data = stim_words[base+5];
            rec_pkt[r].src1_preg = stim_words[base+6][5:0];
            rec_pkt[r].src1_rdy  = stim_words[base+7][0];
            rec_pkt[r].src1_data = stim_words[base+8];
            rec_pkt[r].dst_preg  = stim_words[base+9][5:0];
            rec_exp[r]           = stim_words[base+10];
            rec_mark[r]          = int'(stim_words[base+11]);
            num_recs++;
        end
    endtask

    function automatic logic lane_ready(input int lane);
        return (lane == 0) ? dispatch0_ready : dispatch1_ready;
    endfunction

    task automatic set_dispatch(input int lane, input logic valid,
                                input ooo_backend_pkg::issue_pkt_t pkt);
        if (lane == 0) begin
            dispatch0_valid = valid;
            dispatch0_pkt   = pkt;
        end else begin
            dispatch1_valid = valid;
            dispatch1_pkt   = pkt;
        end
    endtask

    // runs between falling edges, ready is stable there
    task automatic drive_lane(input int lane, input int first, input int last);
        int gap;
        int waited;
        for (int r = first; r <= last; r++) begin
            if (rec_lane[r] != lane) begin
                continue;
            end
            if (rec_mark[r] == 2) begin
                gap = 0;   // pile-up lane is driven back to back
            end else begin
                gap = random_bits(2);
            end
            repeat (gap) @(negedge clk);
            set_dispatch(lane, 1'b1, rec_pkt[r]);
            waited = 0;
            while (!lane_ready(lane)) begin
                ready_dropped[lane] = 1'b1;
                if (waited >= TIMEOUT) begin
                    $display("lane %0d: dispatch of tag %h was never accepted",
                             lane, rec_pkt[r].dst_preg);
                    timed_out = 1'b1;
                    set_dispatch(lane, 1'b0, '0);
                    return;
                end
                @(negedge clk);
                waited++;
            end
            @(negedge clk);   // accepted at the rising edge in between
            set_dispatch(lane, 1'b0, '0);
        end
    endtask

    task automatic pulse_flush();
        repeat (4) @(negedge clk);
        flush_i = 1'b1;
        @(negedge clk);
        if (dispatch0_ready || dispatch1_ready) begin
            $display("dispatch ready stayed high while the flush was applied");
            tb_errors++;
        end
        flush_i = 1'b0;
        @(negedge clk);
        if (!dispatch0_ready || !dispatch1_ready) begin
            $display("dispatch ready did not return high after the flush");
            tb_errors++;
        end
    endtask

    task automatic run_test(input int first, input int last);
        int   errs_before;
        int   errs;
        int   waited;
        logic has_flush;
        logic [1:0] want_drop;
        errs_before   = tb_errors + cdb_checker_i.error_count;
        has_flush     = 1'b0;
        want_drop     = 2'b00;
        ready_dropped = 2'b00;
        for (int r = first; r <= last; r++) begin
            if (rec_mark[r] == 1) begin
                has_flush = 1'b1;   // these tags must never show up
            end else begin
                cdb_checker_i.add_expected(rec_pkt[r].dst_preg, rec_exp[r]);
            end
            if (rec_mark[r] == 2) begin
                want_drop[rec_lane[r]] = 1'b1;
            end
        end
        fork
            drive_lane(0, first, last);
            drive_lane(1, first, last);
        join
        if (timed_out) begin
            return;
        end
        if (has_flush) begin
            pulse_flush();
        end
        waited = 0;
        while (cdb_checker_i.outstanding > 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (cdb_checker_i.outstanding > 0) begin
            $display("test %0d: results still missing after %0d cycles", rec_test[first], waited);
            cdb_checker_i.report_missing();
        end
        if ((want_drop & ~ready_dropped) != 2'b00) begin
            $display("test %0d: dispatch ready never dropped under back-pressure",
                     rec_test[first]);
            tb_errors++;
        end
        repeat (8) @(negedge clk);   // catch late stray broadcasts
        errs = tb_errors + cdb_checker_i.error_count - errs_before;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d ok", rec_test[first]);
        end else begin
            $display("test %0d: %0d errors", rec_test[first], errs);
            tests_failed++;
        end
    endtask

    initial begin
        int first;
        int last;
        int total;
        arst_n_i        = 1'b0;
        flush_i         = 1'b0;
        dispatch0_valid = 1'b0;
        dispatch1_valid = 1'b0;
        dispatch0_pkt   = '0;
        dispatch1_pkt   = '0;
        lfsr_state      = 32'hb0585e06;
        timed_out       = 1'b0;
        ready_dropped   = 2'b00;
        tb_errors       = 0;
        tests_run       = 0;
        tests_failed    = 0;
        load_stimulus();
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        if (cdb_valid !== 1'b0 || dispatch0_ready !== 1'b1 || dispatch1_ready !== 1'b1) begin
            $display("outputs not in their reset state after reset");
            tb_errors++;
        end
        first = 0;
        while (first < num_recs && !timed_out) begin
            last = first;
            while (last + 1 < num_recs && rec_test[last+1] == rec_test[first]) begin
                last++;
            end
            run_test(first, last);
            first = last + 1;
        end
        total = tb_errors + cdb_checker_i.error_count;
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total);
        if (total == 0 && !timed_out && num_recs > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ooo_backend_stimulus.txt */
// test lane op s0_preg s0_rdy s0_data s1_preg s1_rdy s1_data dst expected mark
// hex; op 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sll 7 srl; mark 1 flushed, 2 lane stalls
01 0 0 00 1 00000010 00 1 00000020 01 00000030 0
01 1 1 00 1 00000005 00 1 00000007 02 fffffffe 0
01 0 2 00 1 0000ff0f 00 1 000f0ff0 03 00000f00 0
01 1 3 00 1 a0000000 00 1 0000000a 04 a000000a 0
01 0 4 00 1 ffff0000 00 1 0ff00ff0 05 f00f0ff0 0
01 1 5 00 1 ffffffff 00 1 00000001 06 00000001 0
01 0 6 00 1 00000003 00 1 00000024 07 00000030 0
01 1 7 00 1 80000000 00 1 0000001f 08 00000001 0
01 0 5 00 1 00000002 00 1 fffffffe 09 00000000 0
// wakeup chains across both lanes
02 0 6 11 0 00000000 00 1 00000003 12 00000010 0
02 1 1 10 0 00000000 00 1 00000005 11 00000002 0
02 0 0 00 1 00000003 00 1 00000004 10 00000007 0
02 1 3 12 0 00000000 13 0 00000000 14 00000015 0
02 1 4 00 1 0000000f 00 1 0000000a 13 00000005 0
02 0 0 14 0 00000000 00 1 00000100 15 00000115 0
// bursts on both lanes
03 0 0 00 1 11111111 00 1 22222222 40 33333333 0
03 1 4 00 1 aaaaaaaa 00 1 55555555 41 ffffffff 0
03 0 1 00 1 00000100 00 1 00000001 42 000000ff 0
03 1 0 00 1 7fffffff 00 1 00000001 43 80000000 0
03 0 2 00 1 ffffffff 00 1 12345678 44 12345678 0
03 1 3 00 1 00f000f0 00 1 0f000f00 45 0ff00ff0 0
03 0 7 00 1 0000ff00 00 1 00000008 46 000000ff 0
03 1 6 00 1 00000001 00 1 0000001f 47 80000000 0
03 0 5 00 1 80000000 00 1 00000001 48 00000001 0
03 1 4 00 1 12345678 00 1 12345678 49 00000000 0
03 0 0 00 1 ffffffff 00 1 00000001 4a 00000000 0
03 1 1 00 1 00000000 00 1 00000001 4b ffffffff 0
// lane 1 chain produces tag 36 last, lane 0 piles up behind it
04 1 0 00 1 00000001 00 1 00000001 30 00000002 0
04 1 0 30 0 00000000 00 1 00000001 31 00000003 0
04 1 0 31 0 00000000 00 1 00000001 32 00000004 0
04 1 0 32 0 00000000 00 1 00000001 33 00000005 0
04 1 0 33 0 00000000 00 1 00000001 34 00000006 0
04 1 0 34 0 00000000 00 1 00000001 35 00000007 0
04 1 0 35 0 00000000 00 1 00000001 36 00000008 0
04 0 0 36 0 00000000 00 1 00000001 37 00000009 2
04 0 0 36 0 00000000 00 1 00000002 38 0000000a 2
04 0 0 36 0 00000000 00 1 00000003 39 0000000b 2
04 0 0 36 0 00000000 00 1 00000004 3a 0000000c 2
04 0 0 37 0 00000000 00 1 00000010 3b 00000019 2
04 0 1 37 0 00000000 00 1 00000001 3c 00000008 2
// waiting on tag 3f which nobody produces, then flushed
05 0 0 3f 0 00000000 00 1 00000001 20 00000000 1
05 0 0 3f 0 00000000 00 1 00000002 21 00000000 1
05 0 0 3f 0 00000000 00 1 00000003 22 00000000 1
05 1 0 3f 0 00000000 00 1 00000004 23 00000000 1
06 1 0 00 1 00000005 00 1 00000006 24 0000000b 0
06 0 4 00 1 0000f0f0 00 1 00000ff0 25 0000ff00 0
ff 0 0 00 0 00000000 00 0 00000000 00 00000000 0

/* ooo_backend.f */
ooo_backend_pkg.sv
alu.sv
alu_iq.sv
result_fifo.sv
cdb_arbiter.sv
ooo_backend.sv
cdb_checker.sv
tb_ooo_backend.sv
